//--- design/bp_pkg.sv
package bp_pkg;

    localparam int fetch_width = 4;                 // instruction slots per fetch group
    localparam int xlen = 32;
    localparam int offset_bits = 2;                 // byte offset, always zero for word aligned
    localparam int word_bytes = 4;

    localparam int bht_entries = 128;
    localparam int bht_index_bits = $clog2(bht_entries);
    localparam int history_bits = 7;                // also log2 of the pattern table size
    localparam int pht_entries = 1 << history_bits;

    localparam int btb_sets = 32;
    localparam int btb_ways = 4;
    localparam int btb_set_bits = $clog2(btb_sets);
    localparam int btb_tag_bits = xlen - btb_set_bits - offset_bits;   // 25

    localparam logic [1:0] counter_reset = 2'b01;   // weakly not taken
    localparam logic [xlen-1:0] group_bytes = fetch_width * word_bytes;

    // one fetch address, seen either by the history table or by the target buffer
    typedef union packed {
        struct packed {
            logic [xlen-bht_index_bits-offset_bits-1:0] upper;
            logic [bht_index_bits-1:0]                  index;
            logic [offset_bits-1:0]                     offset;
        } hist;
        struct packed {
            logic [btb_tag_bits-1:0]                    tag;
            logic [btb_set_bits-1:0]                    set_index;
            logic [offset_bits-1:0]                     offset;
        } btb;
    } bp_pc_t;

endpackage

//--- design/local_history_predictor.sv
`timescale 1ns/100ps

module local_history_predictor (
    input  logic                                                clock,
    input  logic                                                reset,
    input  logic [bp_pkg::xlen-1:0]                             pc,
    input  logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]    pc_update,
    input  logic [bp_pkg::fetch_width-1:0]                      direction_update,
    input  logic [bp_pkg::fetch_width-1:0]                      valid_update,
    output logic [bp_pkg::fetch_width-1:0]                      slot_taken
);

    // per-branch local history and the shared pattern counters
    logic [bp_pkg::bht_entries-1:0][bp_pkg::history_bits-1:0]  bht;
    logic [bp_pkg::pht_entries-1:0][1:0]                        pht;

    // lookup side
    bp_pkg::bp_pc_t [bp_pkg::fetch_width-1:0]                   look_view;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::history_bits-1:0]  look_history;

    // commit side, all taken from the state before the edge
    bp_pkg::bp_pc_t [bp_pkg::fetch_width-1:0]                   upd_view;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::history_bits-1:0]  upd_history;
    logic [bp_pkg::fetch_width-1:0][1:0]                        upd_counter;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::history_bits-1:0]  next_history;
    logic [bp_pkg::fetch_width-1:0][1:0]                        next_counter;

    // slot i uses the address pc + 4i, so its index is the group index plus i
    always_comb begin
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            look_view[i] = pc + bp_pkg::word_bytes * i;
            look_history[i] = bht[look_view[i].hist.index];
            slot_taken[i] = pht[look_history[i]][1];   // counter msb is the direction
        end
    end

    always_comb begin
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            upd_view[i] = pc_update[i];
            upd_history[i] = bht[upd_view[i].hist.index];
            upd_counter[i] = pht[upd_history[i]];

            // shift in the resolved direction
            next_history[i] = {upd_history[i][bp_pkg::history_bits-2:0], direction_update[i]};

            if (direction_update[i]) begin
                if (upd_counter[i] == 2'b11) begin
                    next_counter[i] = upd_counter[i];          // saturated taken
                end else begin
                    next_counter[i] = upd_counter[i] + 2'd1;
                end
            end else begin
                if (upd_counter[i] == 2'b00) begin
                    next_counter[i] = upd_counter[i];          // saturated not taken
                end else begin
                    next_counter[i] = upd_counter[i] - 2'd1;
                end
            end
        end
    end

    // later slots overwrite earlier ones that hit the same entry
    always_ff @(posedge clock) begin
        if (reset) begin
            bht <= '0;
            pht <= {bp_pkg::pht_entries{bp_pkg::counter_reset}};
        end else begin
            for (int i = 0; i < bp_pkg::fetch_width; i++) begin
                if (valid_update[i]) begin
                    bht[upd_view[i].hist.index] <= next_history[i];
                    pht[upd_history[i]] <= next_counter[i];   // counter picked by old history
                end
            end
        end
    end

endmodule

//--- design/branch_target_buffer.sv
`timescale 1ns/100ps

module branch_target_buffer (
    input  logic                                                clock,
    input  logic                                                reset,
    input  logic [bp_pkg::xlen-1:0]                             pc,
    input  logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]    pc_update,
    input  logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]    target_update,
    input  logic [bp_pkg::fetch_width-1:0]                      write_strobe,
    output logic [bp_pkg::fetch_width-1:0]                      slot_hit,
    output logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]    slot_target
);

    // way 0 holds the most recently written entry, way 3 the oldest
    logic [bp_pkg::btb_sets-1:0][bp_pkg::btb_ways-1:0]                          btb_valid;
    logic [bp_pkg::btb_sets-1:0][bp_pkg::btb_ways-1:0][bp_pkg::btb_tag_bits-1:0] btb_tag;
    logic [bp_pkg::btb_sets-1:0][bp_pkg::btb_ways-1:0][bp_pkg::xlen-1:0]         btb_target;

    // lookup side
    bp_pkg::bp_pc_t [bp_pkg::fetch_width-1:0]                       look_view;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::btb_set_bits-1:0]      look_set;

    // per-slot image of the set after its write
    bp_pkg::bp_pc_t [bp_pkg::fetch_width-1:0]                       upd_view;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::btb_set_bits-1:0]      upd_set;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::btb_ways-1:0]          new_valid;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::btb_ways-1:0][bp_pkg::btb_tag_bits-1:0] new_tag;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::btb_ways-1:0][bp_pkg::xlen-1:0]         new_target;

    always_comb begin
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            look_view[i] = pc + bp_pkg::word_bytes * i;
            look_set[i] = look_view[i].btb.set_index;
            slot_hit[i] = 1'b0;
            slot_target[i] = '0;
            // scan from the oldest way down so the youngest match is kept
            for (int j = bp_pkg::btb_ways - 1; j >= 0; j--) begin
                if (btb_valid[look_set[i]][j] &&
                    btb_tag[look_set[i]][j] == look_view[i].btb.tag) begin
                    slot_hit[i] = 1'b1;
                    slot_target[i] = btb_target[look_set[i]][j];
                end
            end
        end
    end

    always_comb begin
        int stop;
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            upd_view[i] = pc_update[i];
            upd_set[i] = upd_view[i].btb.set_index;

            // position of the old copy, or one past the last way when absent
            stop = bp_pkg::btb_ways;
            for (int j = bp_pkg::btb_ways - 1; j >= 0; j--) begin
                if (btb_valid[upd_set[i]][j] &&
                    btb_tag[upd_set[i]][j] == upd_view[i].btb.tag) begin
                    stop = j;
                end
            end

            new_valid[i][0] = 1'b1;                     // new entry goes to the front
            new_tag[i][0] = upd_view[i].btb.tag;
            new_target[i][0] = target_update[i];

            for (int j = 1; j < bp_pkg::btb_ways; j++) begin
                if (j <= stop) begin
                    new_valid[i][j] = btb_valid[upd_set[i]][j-1];   // push down one way
                    new_tag[i][j] = btb_tag[upd_set[i]][j-1];
                    new_target[i][j] = btb_target[upd_set[i]][j-1];
                end else begin
                    new_valid[i][j] = btb_valid[upd_set[i]][j];
                    new_tag[i][j] = btb_tag[upd_set[i]][j];
                    new_target[i][j] = btb_target[upd_set[i]][j];
                end
            end
        end
    end

    // the whole set is rewritten, so a higher slot replaces a lower one completely
    always_ff @(posedge clock) begin
        if (reset) begin
            btb_valid <= '0;
        end else begin
            for (int i = 0; i < bp_pkg::fetch_width; i++) begin
                if (write_strobe[i]) begin
                    btb_valid[upd_set[i]] <= new_valid[i];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            if (write_strobe[i]) begin
                btb_tag[upd_set[i]] <= new_tag[i];
                btb_target[upd_set[i]] <= new_target[i];
            end
        end
    end

endmodule

//--- design/fetch_redirect.sv
`timescale 1ns/100ps

module fetch_redirect (
    input  logic [bp_pkg::xlen-1:0]                             pc,
    input  logic [bp_pkg::fetch_width-1:0]                      is_branch,
    input  logic [bp_pkg::fetch_width-1:0]                      is_valid,
    input  logic [bp_pkg::fetch_width-1:0]                      slot_taken,
    input  logic [bp_pkg::fetch_width-1:0]                      slot_hit,
    input  logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]    slot_target,
    output logic [bp_pkg::xlen-1:0]                             next_pc,
    output logic [bp_pkg::fetch_width-1:0]                      predictions
);

    logic [bp_pkg::fetch_width-1:0] candidate;   // slots able to redirect fetch
    logic                           found;

    // a slot redirects only with a direction and a target to go to
    assign candidate = is_branch & is_valid & slot_taken & slot_hit;

    always_comb begin
        next_pc = pc + bp_pkg::group_bytes;         // fall through to the next group
        predictions = '0;
        found = 1'b0;

        // oldest slot first, later slots are not fetched after a taken branch
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            if (candidate[i] && !found) begin
                next_pc = slot_target[i];
                predictions[i] = 1'b1;
                found = 1'b1;
            end
        end
    end

endmodule

//--- design/fetch_predictor.sv
`timescale 1ns/100ps

module fetch_predictor (
    input  logic                                                clock,
    input  logic                                                reset,
    input  logic [bp_pkg::xlen-1:0]                             pc,
    input  logic [bp_pkg::fetch_width-1:0]                      is_branch,
    input  logic [bp_pkg::fetch_width-1:0]                      is_valid,
    input  logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]    pc_update,
    input  logic [bp_pkg::fetch_width-1:0]                      direction_update,
    input  logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]    target_update,
    input  logic [bp_pkg::fetch_width-1:0]                      valid_update,
    output logic [bp_pkg::xlen-1:0]                             next_pc,
    output logic [bp_pkg::fetch_width-1:0]                      predictions
);

    logic [bp_pkg::fetch_width-1:0]                     slot_taken;
    logic [bp_pkg::fetch_width-1:0]                     slot_hit;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]   slot_target;
    logic [bp_pkg::fetch_width-1:0]                     btb_write;

    // only committed taken branches allocate a target entry
    assign btb_write = valid_update & direction_update;

    local_history_predictor direction (
        .clock            (clock),
        .reset            (reset),
        .pc               (pc),
        .pc_update        (pc_update),
        .direction_update (direction_update),
        .valid_update     (valid_update),
        .slot_taken       (slot_taken)
    );

    branch_target_buffer targets (
        .clock         (clock),
        .reset         (reset),
        .pc            (pc),
        .pc_update     (pc_update),
        .target_update (target_update),
        .write_strobe  (btb_write),
        .slot_hit      (slot_hit),
        .slot_target   (slot_target)
    );

    fetch_redirect redirect (
        .pc          (pc),
        .is_branch   (is_branch),
        .is_valid    (is_valid),
        .slot_taken  (slot_taken),
        .slot_hit    (slot_hit),
        .slot_target (slot_target),
        .next_pc     (next_pc),
        .predictions (predictions)
    );

endmodule

//--- dv/fetch_predictor_checker.sv
`timescale 1ns/100ps

module fetch_predictor_checker (
    input  logic                                                clock,
    input  logic                                                reset,
    input  logic [bp_pkg::xlen-1:0]                             pc,
    input  logic [bp_pkg::fetch_width-1:0]                      is_branch,
    input  logic [bp_pkg::fetch_width-1:0]                      is_valid,
    input  logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]    pc_update,
    input  logic [bp_pkg::fetch_width-1:0]                      direction_update,
    input  logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]    target_update,
    input  logic [bp_pkg::fetch_width-1:0]                      valid_update,
    input  logic [bp_pkg::xlen-1:0]                             next_pc,
    input  logic [bp_pkg::fetch_width-1:0]                      predictions,
    input  int                                                  phase,
    output int                                                  mismatches,
    output int                                                  checks
);

    // shadow copy of the predictor state
    logic [bp_pkg::bht_entries-1:0][bp_pkg::history_bits-1:0]  hist_table;
    logic [bp_pkg::pht_entries-1:0][1:0]                        counters;
    logic [bp_pkg::btb_sets-1:0][bp_pkg::btb_ways-1:0]          way_valid;
    // word address of each entry, byte offset dropped
    logic [bp_pkg::btb_sets-1:0][bp_pkg::btb_ways-1:0][bp_pkg::xlen-1:bp_pkg::offset_bits] way_word;
    logic [bp_pkg::btb_sets-1:0][bp_pkg::btb_ways-1:0][bp_pkg::xlen-1:0] way_target;

    logic [bp_pkg::fetch_width-1:0] exp_mask;
    logic [bp_pkg::xlen-1:0]        exp_next;

    function automatic string phase_name(input int p);
        case (p)
            1:       return "after_reset";
            2:       return "training";
            3:       return "slot_priority";
            4:       return "btb_replacement";
            5:       return "random";
            6:       return "reset_mid_run";
            default: return "unknown";
        endcase
    endfunction

    // expected {predictions, next_pc} for one fetch group
    function automatic logic [bp_pkg::fetch_width+bp_pkg::xlen-1:0] reference_prediction(
        input logic [bp_pkg::xlen-1:0]        group_pc,
        input logic [bp_pkg::fetch_width-1:0] branch,
        input logic [bp_pkg::fetch_width-1:0] valid
    );
        logic [bp_pkg::xlen-1:0]          slot_addr;
        bp_pkg::bp_pc_t                   view;
        logic [bp_pkg::history_bits-1:0]  history;
        logic [bp_pkg::btb_set_bits-1:0]  set_index;
        logic                             hit;
        logic [bp_pkg::xlen-1:0]          target;
        logic [bp_pkg::fetch_width-1:0]   mask;
        logic [bp_pkg::xlen-1:0]          next;
        mask = '0;
        next = group_pc + 32'd16;                       // fall through
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            slot_addr = group_pc + 4 * i;
            view = slot_addr;
            history = hist_table[view.hist.index];
            set_index = view.btb.set_index;
            hit = 1'b0;
            target = '0;
            for (int w = 0; w < bp_pkg::btb_ways; w++) begin
                if (!hit && way_valid[set_index][w] &&
                    way_word[set_index][w] == slot_addr[bp_pkg::xlen-1:bp_pkg::offset_bits]) begin
                    hit = 1'b1;
                    target = way_target[set_index][w];
                end
            end
            if (mask == '0 && branch[i] && valid[i] && counters[history][1] && hit) begin
                mask[i] = 1'b1;                         // first taken slot ends the group
                next = target;
            end
        end
        return {mask, next};
    endfunction

    task automatic clear_shadow();
        hist_table = '0;
        counters = {bp_pkg::pht_entries{bp_pkg::counter_reset}};
        way_valid = '0;
    endtask

    // every slot sees the state from before the edge, later slots overwrite
    task automatic apply_commits();
        logic [bp_pkg::bht_entries-1:0][bp_pkg::history_bits-1:0] old_hist;
        logic [bp_pkg::pht_entries-1:0][1:0]                       old_counters;
        logic [bp_pkg::btb_sets-1:0][bp_pkg::btb_ways-1:0]         old_valid;
        logic [bp_pkg::btb_sets-1:0][bp_pkg::btb_ways-1:0][bp_pkg::xlen-1:bp_pkg::offset_bits] old_word;
        logic [bp_pkg::btb_sets-1:0][bp_pkg::btb_ways-1:0][bp_pkg::xlen-1:0] old_target;
        bp_pkg::bp_pc_t                   view;
        logic [bp_pkg::history_bits-1:0]  history;
        logic [1:0]                       count;
        logic [bp_pkg::btb_set_bits-1:0]  set_index;
        int                               pos;
        old_hist = hist_table;
        old_counters = counters;
        old_valid = way_valid;
        old_word = way_word;
        old_target = way_target;
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            view = pc_update[i];
            if (valid_update[i]) begin
                history = old_hist[view.hist.index];
                count = old_counters[history];
                hist_table[view.hist.index] = {history[bp_pkg::history_bits-2:0],
                                               direction_update[i]};
                if (direction_update[i] && count != 2'b11) begin
                    count = count + 2'd1;
                end else if (!direction_update[i] && count != 2'b00) begin
                    count = count - 2'd1;
                end
                counters[history] = count;
            end
            if (valid_update[i] && direction_update[i]) begin
                set_index = view.btb.set_index;
                pos = bp_pkg::btb_ways;                 // not resident, oldest falls out
                for (int w = bp_pkg::btb_ways - 1; w >= 0; w--) begin
                    if (old_valid[set_index][w] &&
                        old_word[set_index][w] == pc_update[i][bp_pkg::xlen-1:bp_pkg::offset_bits]) begin
                        pos = w;
                    end
                end
                for (int w = 1; w < bp_pkg::btb_ways; w++) begin
                    way_valid[set_index][w] = (w <= pos) ? old_valid[set_index][w-1]
                                                         : old_valid[set_index][w];
                    way_word[set_index][w] = (w <= pos) ? old_word[set_index][w-1]
                                                        : old_word[set_index][w];
                    way_target[set_index][w] = (w <= pos) ? old_target[set_index][w-1]
                                                          : old_target[set_index][w];
                end
                way_valid[set_index][0] = 1'b1;
                way_word[set_index][0] = pc_update[i][bp_pkg::xlen-1:bp_pkg::offset_bits];
                way_target[set_index][0] = target_update[i];
            end
        end
    endtask

    initial begin
        mismatches = 0;
        checks = 0;
    end

    // compare first, then advance the shadow by this edge's commits
    always @(posedge clock) begin
        if (reset) begin
            clear_shadow();
        end else begin
            {exp_mask, exp_next} = reference_prediction(pc, is_branch, is_valid);
            checks = checks + 1;
            if (predictions !== exp_mask) begin
                mismatches = mismatches + 1;
                $display("[FAIL] %s: predictions for pc %h expected %b, actual %b at %0t",
                         phase_name(phase), pc, exp_mask, predictions, $time);
            end
            if (next_pc !== exp_next) begin
                mismatches = mismatches + 1;
                $display("[FAIL] %s: next_pc for pc %h expected %h, actual %h at %0t",
                         phase_name(phase), pc, exp_next, next_pc, $time);
            end
            apply_commits();
        end
    end

endmodule

//--- dv/fetch_predictor_tb.sv
`timescale 1ns/100ps

module fetch_predictor_tb;

    logic                                               clock;
    logic                                               reset;
    logic [bp_pkg::xlen-1:0]                            pc;
    logic [bp_pkg::fetch_width-1:0]                     is_branch;
    logic [bp_pkg::fetch_width-1:0]                     is_valid;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]   pc_update;
    logic [bp_pkg::fetch_width-1:0]                     direction_update;
    logic [bp_pkg::fetch_width-1:0][bp_pkg::xlen-1:0]   target_update;
    logic [bp_pkg::fetch_width-1:0]                     valid_update;
    logic [bp_pkg::xlen-1:0]                            next_pc;
    logic [bp_pkg::fetch_width-1:0]                     predictions;

    int          phase;
    int          mismatches;
    int          checks;
    int          tb_errors;
    logic [31:0] lcg_state;

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;             // 100 ns period
    end

    fetch_predictor UUT (
        .clock            (clock),
        .reset            (reset),
        .pc               (pc),
        .is_branch        (is_branch),
        .is_valid         (is_valid),
        .pc_update        (pc_update),
        .direction_update (direction_update),
        .target_update    (target_update),
        .valid_update     (valid_update),
        .next_pc          (next_pc),
        .predictions      (predictions)
    );

    fetch_predictor_checker prediction_check (
        .clock            (clock),
        .reset            (reset),
        .pc               (pc),
        .is_branch        (is_branch),
        .is_valid         (is_valid),
        .pc_update        (pc_update),
        .direction_update (direction_update),
        .target_update    (target_update),
        .valid_update     (valid_update),
        .next_pc          (next_pc),
        .predictions      (predictions),
        .phase            (phase),
        .mismatches       (mismatches),
        .checks           (checks)
    );

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];                // low bits of an lcg repeat quickly
    endfunction

    function automatic logic [3:0] random_nibble();
        return next_random() % 16;
    endfunction

    // word-aligned addresses over 1024 words so history and buffer entries alias often
    function automatic logic [31:0] random_pc();
        return 32'h0000_4000 + (next_random() % 1024) * 4;
    endfunction

    task automatic clear_commits();
        pc_update = '0;
        direction_update = '0;
        target_update = '0;
        valid_update = '0;
    endtask

    task automatic lookup(input logic [31:0] addr, input logic [3:0] branch,
                          input logic [3:0] valid);
        pc = addr;
        is_branch = branch;
        is_valid = valid;
    endtask

    task automatic commit_slot(input int slot, input logic [31:0] addr, input logic valid,
                               input logic taken, input logic [31:0] target);
        pc_update[slot] = addr;
        valid_update[slot] = valid;
        direction_update[slot] = taken;
        target_update[slot] = target;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        clear_commits();
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    endtask

    // sample halfway between the falling and the next rising edge
    task automatic expect_lookup(input string name, input logic [3:0] exp_mask,
                                 input logic [31:0] exp_next);
        #25;
        if (predictions !== exp_mask) begin
            tb_errors++;
            $display("[FAIL] %s: predictions expected %b, actual %b", name, exp_mask, predictions);
        end
        if (next_pc !== exp_next) begin
            tb_errors++;
            $display("[FAIL] %s: next_pc expected %h, actual %h", name, exp_next, next_pc);
        end
    endtask

    // keep committing the branch taken until the lookup shows it taken
    task automatic train_branch(input string name, input logic [31:0] addr,
                                input logic [31:0] target, input logic [31:0] group,
                                input logic [3:0] branch, input logic [3:0] exp_mask);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 20) begin
            @(negedge clock);
            clear_commits();
            commit_slot(0, addr, 1'b1, 1'b1, target);
            lookup(group, branch, 4'b1111);
            #25;
            seen = (predictions === exp_mask);
            cycles++;
        end
        if (!seen) begin
            tb_errors++;
            $display("timeout in %s: branch %h was not predicted taken after %0d commits",
                     name, addr, cycles);
        end
    endtask

    task automatic check_resident(input string name, input logic [31:0] addr,
                                  input logic [31:0] target, input bit resident);
        @(negedge clock);
        clear_commits();
        lookup(addr, 4'b0001, 4'b0001);
        expect_lookup(name, resident ? 4'b0001 : 4'b0000, resident ? target : addr + 32'd16);
    endtask

    initial begin
        logic [31:0] addr;
        tb_errors = 0;
        lcg_state = 32'd95909;
        phase = 1;
        lookup(32'h0, 4'h0, 4'h0);
        apply_reset();

        repeat (20) begin
            @(negedge clock);
            addr = random_pc();
            lookup(addr, random_nibble(), random_nibble());
            expect_lookup("after_reset", 4'b0000, addr + 32'd16);
        end

        phase = 2;
        train_branch("training", 32'h0000_1008, 32'h0000_2400, 32'h0000_1000, 4'b0100, 4'b0100);
        @(negedge clock);
        clear_commits();
        lookup(32'h0000_1000, 4'b0100, 4'b1111);
        expect_lookup("training", 4'b0100, 32'h0000_2400);

        phase = 3;
        train_branch("slot_priority", 32'h0000_100c, 32'h0000_3000, 32'h0000_1000, 4'b1000,
                     4'b1000);
        @(negedge clock);
        clear_commits();
        lookup(32'h0000_1000, 4'b1100, 4'b1111);
        expect_lookup("slot_priority", 4'b0100, 32'h0000_2400);     // lower slot wins
        @(negedge clock);
        lookup(32'h0000_1000, 4'b1000, 4'b1111);
        expect_lookup("slot_priority", 4'b1000, 32'h0000_3000);
        @(negedge clock);
        lookup(32'h0000_1000, 4'b1100, 4'b1011);
        expect_lookup("slot_priority", 4'b1000, 32'h0000_3000);
        @(negedge clock);
        lookup(32'h0000_1000, 4'b1100, 4'b0011);
        expect_lookup("slot_priority", 4'b0000, 32'h0000_1010);

        // five branches in set 9 leave E4 E3 E2 E1 in the ways and push E0 out
        phase = 4;
        for (int k = 0; k < 5; k++) begin
            @(negedge clock);
            clear_commits();
            commit_slot(0, 32'h0000_8024 + k * 32'h80, 1'b1, 1'b1, 32'h0000_a000 + k * 32'h100);
        end
        check_resident("btb_replacement", 32'h0000_8024, 32'h0000_a000, 1'b0);
        for (int k = 1; k < 5; k++) begin
            check_resident("btb_replacement", 32'h0000_8024 + k * 32'h80,
                           32'h0000_a000 + k * 32'h100, 1'b1);
        end
        @(negedge clock);
        commit_slot(0, 32'h0000_80a4, 1'b1, 1'b1, 32'h0000_a100);  // E1 back to way 0
        @(negedge clock);
        commit_slot(0, 32'h0000_8024, 1'b1, 1'b1, 32'h0000_a000);  // E0 now pushes out E2
        check_resident("btb_replacement", 32'h0000_8124, 32'h0000_a200, 1'b0);
        check_resident("btb_replacement", 32'h0000_80a4, 32'h0000_a100, 1'b1);
        check_resident("btb_replacement", 32'h0000_8024, 32'h0000_a000, 1'b1);

        phase = 5;
        repeat (3000) begin
            @(negedge clock);
            lookup(random_pc(), random_nibble(), random_nibble());
            for (int i = 0; i < bp_pkg::fetch_width; i++) begin
                if (i > 0 && next_random() % 6 == 0) begin
                    addr = pc_update[i-1];              // two slots on the same entry
                end else begin
                    addr = random_pc();
                end
                commit_slot(i, addr, next_random() % 4 != 0, next_random() % 4 != 0,
                            random_pc() + 32'h0001_0000);
            end
        end

        // seven commits fill the history and three more lift its counter to 11
        phase = 6;
        repeat (10) begin
            @(negedge clock);
            clear_commits();
            commit_slot(0, 32'h0000_1008, 1'b1, 1'b1, 32'h0000_2400);
        end
        @(negedge clock);
        clear_commits();
        lookup(32'h0000_1000, 4'b0100, 4'b1111);
        expect_lookup("reset_mid_run", 4'b0100, 32'h0000_2400);
        @(negedge clock);
        apply_reset();
        @(negedge clock);
        lookup(32'h0000_1000, 4'b0100, 4'b1111);
        expect_lookup("reset_mid_run", 4'b0000, 32'h0000_1010);
        repeat (20) begin
            @(negedge clock);
            addr = random_pc();
            lookup(addr, random_nibble(), random_nibble());
            expect_lookup("reset_mid_run", 4'b0000, addr + 32'd16);
        end

        @(negedge clock);
        if (checks == 0) begin
            tb_errors++;
            $display("the checker never compared any output");
        end
        $display("checks %0d, checker mismatches %0d, testbench errors %0d",
                 checks, mismatches, tb_errors);
        if (tb_errors == 0 && mismatches == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- fetch_predictor.f
design/bp_pkg.sv
design/local_history_predictor.sv
design/branch_target_buffer.sv
design/fetch_redirect.sv
design/fetch_predictor.sv
dv/fetch_predictor_checker.sv
dv/fetch_predictor_tb.sv
